//--- Bender.yml
package:
  name: csr

sources:
  - include_dirs:
      - src
    files:
      - src/csr_pkg.sv
      - src/csr_mode_exc.sv
      - src/csr_interrupt.sv
      - src/csr_timer.sv
      - src/csr_scratch.sv
      - src/csr_read_mux.sv
      - src/csr_top.sv
  - target: test
    include_dirs:
      - src
      - sim
    files:
      - sim/csr_tb.sv

//--- all.f
+incdir+src
+incdir+sim
src/csr_pkg.sv
src/csr_mode_exc.sv
src/csr_interrupt.sv
src/csr_timer.sv
src/csr_scratch.sv
src/csr_read_mux.sv
src/csr_top.sv
sim/csr_tb.sv

//--- sim/csr_tb_tasks.svh
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

// Expected register state from the architectural rules
plv_t       exp_plv;
logic       exp_ie;
logic       exp_da;
logic       exp_pg;
logic [3:0] exp_dat;
csr_data_t  exp_prmd;
csr_data_t  exp_era;
csr_data_t  exp_badv;
ecode_t     exp_ecode;

// DATM and DATF travel together in exp_dat
function automatic csr_data_t crmd_word();
    return {23'd0, exp_dat, exp_pg, exp_da, exp_ie, exp_plv};
endfunction

task automatic next_cycle();
    @(posedge clk);
    #2;
endtask

task automatic fail_run();
    $display("TEST FAILED");
    $fatal(1);
endtask

task automatic compare_word(input csr_data_t got, input csr_data_t expected, input string what);
    assert (got === expected) else begin
        $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        fail_run();
    end
endtask

task automatic require(input logic cond, input string what);
    assert (cond === 1'b1) else begin
        $display("Check failed at %0t ns: %s", $time, what);
        fail_run();
    end
endtask

task automatic write_reg(input csr_addr_t a, input csr_data_t d);
    addr   = a;
    wdata  = d;
    csr_we = 1'b1;
    next_cycle();
    csr_we = 1'b0;
endtask

// Sampled mid cycle after the inputs settle
task automatic read_reg(input csr_addr_t a, output csr_data_t d);
    addr = a;
    #5;
    d = rdata;
    next_cycle();
endtask

task automatic verify_reg(input csr_addr_t a, input csr_data_t expected, input string what);
    csr_data_t d;
    read_reg(a, d);
    compare_word(d, expected, what);
endtask

task automatic check_irq_lines(input logic exp_cpu, input logic exp_idle);
    #5;
    compare_word(32'(cpu_interrupt), 32'(exp_cpu), "cpu_interrupt");
    compare_word(32'(idle_over), 32'(exp_idle), "idle_over");
    next_cycle();
endtask

task automatic set_mode(input plv_t p, input logic ie, input logic da, input logic pg);
    logic [3:0] dat;
    dat = 4'($urandom);
    write_reg(`CSR_ADDR_CRMD, {23'd0, dat, pg, da, ie, p});
    exp_plv = p;
    exp_ie  = ie;
    exp_dat = dat;
    // DA and PG only move to a legal pair
    if (da != pg) begin
        exp_da = da;
        exp_pg = pg;
    end
    verify_reg(`CSR_ADDR_CRMD, crmd_word(), "CRMD");
    compare_word(32'(plv), 32'(exp_plv), "plv");
endtask

task automatic raise_exception(input logic with_badv);
    ex_pc      = $urandom;
    ex_ecode   = 6'($urandom);
    badv_in    = $urandom;
    badv_valid = with_badv;
    exception  = 1'b1;
    next_cycle();
    exception  = 1'b0;
    badv_valid = 1'b0;
    exp_prmd   = {29'd0, exp_ie, exp_plv};
    exp_plv    = '0;
    exp_ie     = 1'b0;
    exp_era    = ex_pc;
    exp_ecode  = ex_ecode;
    if (with_badv) begin
        exp_badv = badv_in;
    end
endtask

task automatic return_from_exception();
    ertn = 1'b1;
    next_cycle();
    ertn    = 1'b0;
    exp_plv = exp_prmd[1:0];
    exp_ie  = exp_prmd[2];
    verify_reg(`CSR_ADDR_CRMD, crmd_word(), "CRMD after ertn");
    compare_word(32'(plv), 32'(exp_plv), "plv after ertn");
endtask

task automatic check_exception_state();
    verify_reg(`CSR_ADDR_CRMD, crmd_word(), "CRMD after exception");
    compare_word(32'(plv), 32'(exp_plv), "plv after exception");
    verify_reg(`CSR_ADDR_PRMD, exp_prmd, "PRMD");
    verify_reg(`CSR_ADDR_ERA, exp_era, "ERA");
    compare_word(era_out, exp_era, "era_out");
    verify_reg(`CSR_ADDR_BADV, exp_badv, "BADV");
    verify_reg(`CSR_ADDR_ESTAT, {10'd0, exp_ecode, 16'd0}, "ESTAT");
endtask

task automatic wait_timer_irq(input int limit);
    csr_data_t d;
    int        n;
    d = '0;
    n = 0;
    while (!d[`CSR_ESTAT_TI_BIT] && n < limit) begin
        read_reg(`CSR_ADDR_ESTAT, d);
        n++;
    end
    require(d[`CSR_ESTAT_TI_BIT], "timer interrupt bit in ESTAT did not set in time");
endtask

`endif

//--- sim/csr_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_tb;
    import csr_pkg::*;

    localparam int CYCLE_LIMIT = 5000;
    localparam int TIMER_INIT  = 3;
    localparam int TIMER_WAIT  = TIMER_INIT * 4 + 4;

    logic      clk;
    logic      aresetn;
    csr_addr_t addr;
    csr_data_t wdata;
    logic      csr_we;
    logic      exception;
    logic      ertn;
    ecode_t    ex_ecode;
    csr_data_t ex_pc;
    logic      badv_valid;
    csr_data_t badv_in;
    hw_int_t   hw_int;
    csr_data_t rdata;
    plv_t      plv;
    csr_data_t era_out;
    csr_data_t eentry_out;
    csr_data_t tid_out;
    logic      cpu_interrupt;
    logic      idle_over;
    int        cycle_count;

    `include "csr_tb_tasks.svh"

    csr_top uut (
        .clk           (clk),
        .aresetn       (aresetn),
        .addr          (addr),
        .wdata         (wdata),
        .csr_we        (csr_we),
        .exception     (exception),
        .ertn          (ertn),
        .ex_ecode      (ex_ecode),
        .ex_pc         (ex_pc),
        .badv_valid    (badv_valid),
        .badv_in       (badv_in),
        .hw_int        (hw_int),
        .rdata         (rdata),
        .plv           (plv),
        .era_out       (era_out),
        .eentry_out    (eentry_out),
        .tid_out       (tid_out),
        .cpu_interrupt (cpu_interrupt),
        .idle_over     (idle_over)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    initial begin
        csr_data_t v;
        int        k;
        void'($urandom(40306));
        clk         = 1'b0;
        aresetn     = 1'b0;
        addr        = '0;
        wdata       = '0;
        csr_we      = 1'b0;
        exception   = 1'b0;
        ertn        = 1'b0;
        ex_ecode    = '0;
        ex_pc       = '0;
        badv_valid  = 1'b0;
        badv_in     = '0;
        hw_int      = '0;
        cycle_count = 0;
        // Architectural reset sets DA, DATF and DATM to 1
        exp_plv   = '0;
        exp_ie    = 1'b0;
        exp_da    = 1'b1;
        exp_pg    = 1'b0;
        exp_dat   = 4'b0101;
        exp_prmd  = '0;
        exp_era   = '0;
        exp_badv  = '0;
        exp_ecode = '0;
        repeat (10) @(posedge clk);
        #2;
        aresetn = 1'b1;

        verify_reg(`CSR_ADDR_CRMD, crmd_word(), "CRMD after reset");
        compare_word(32'(plv), 32'd0, "plv after reset");
        check_irq_lines(1'b0, 1'b0);

        for (k = 0; k < 4; k++) begin
            v = $urandom;
            write_reg(`CSR_ADDR_SAVE0 + 14'(k), v);
            verify_reg(`CSR_ADDR_SAVE0 + 14'(k), v, "SAVE");
        end
        v = $urandom;
        write_reg(`CSR_ADDR_TID, v);
        verify_reg(`CSR_ADDR_TID, v, "TID");
        compare_word(tid_out, v, "tid_out");
        v = $urandom;
        write_reg(`CSR_ADDR_ECFG, v);
        verify_reg(`CSR_ADDR_ECFG, v & 32'h0000_1FFF, "ECFG");
        v = $urandom;
        write_reg(`CSR_ADDR_EENTRY, v);
        verify_reg(`CSR_ADDR_EENTRY, v & ~32'h3F, "EENTRY");
        compare_word(eentry_out, v & ~32'h3F, "eentry_out");
        verify_reg(14'h3FF, 32'd0, "unmapped address");
        verify_reg(`CSR_ADDR_TICLR, 32'd0, "TICLR");

        // Legal and illegal DA/PG pairs
        set_mode(2'd2, 1'b1, 1'b0, 1'b1);
        set_mode(2'd1, 1'b0, 1'b1, 1'b0);
        set_mode(2'd3, 1'b1, 1'b0, 1'b0);
        set_mode(2'd0, 1'b1, 1'b1, 1'b1);

        set_mode(2'd3, 1'b1, 1'b1, 1'b0);
        raise_exception(1'b0);
        check_exception_state();
        return_from_exception();
        raise_exception(1'b1);
        check_exception_state();
        return_from_exception();

        // Hardware line first and then a software bit
        set_mode(2'd0, 1'b0, 1'b1, 1'b0);
        write_reg(`CSR_ADDR_ECFG, 32'd0);
        k = $urandom_range(7, 0);
        hw_int = hw_int_t'(1 << k);
        check_irq_lines(1'b0, 1'b1);
        verify_reg(`CSR_ADDR_ESTAT, {10'd0, exp_ecode, 6'd0, hw_int, 2'd0}, "ESTAT hw bits");
        write_reg(`CSR_ADDR_ECFG, 32'h1 << (k + 2));
        check_irq_lines(1'b0, 1'b1);
        set_mode(2'd0, 1'b1, 1'b1, 1'b0);
        check_irq_lines(1'b1, 1'b1);
        write_reg(`CSR_ADDR_ECFG, 32'h1 << ((k + 1) % 8 + 2));
        check_irq_lines(1'b0, 1'b1);
        hw_int = '0;
        check_irq_lines(1'b0, 1'b0);
        write_reg(`CSR_ADDR_ESTAT, 32'h1);
        check_irq_lines(1'b0, 1'b1);
        write_reg(`CSR_ADDR_ECFG, 32'h1);
        check_irq_lines(1'b1, 1'b1);
        set_mode(2'd0, 1'b0, 1'b1, 1'b0);
        check_irq_lines(1'b0, 1'b1);
        write_reg(`CSR_ADDR_ESTAT, 32'h0);
        check_irq_lines(1'b0, 1'b0);

        // One-shot timer loads InitVal then 01 and counts down
        write_reg(`CSR_ADDR_TCFG, (TIMER_INIT << 2) | 1);
        next_cycle();
        for (k = 0; k < 3; k++) begin
            verify_reg(`CSR_ADDR_TVAL, TIMER_INIT * 4 + 1 - k, "TVAL countdown");
        end
        wait_timer_irq(TIMER_WAIT);
        verify_reg(`CSR_ADDR_TVAL, 32'd0, "TVAL after one-shot expiry");
        verify_reg(`CSR_ADDR_TCFG, (TIMER_INIT << 2) | 1, "TCFG");
        write_reg(`CSR_ADDR_TICLR, 32'h1);
        verify_reg(`CSR_ADDR_ESTAT, {10'd0, exp_ecode, 16'd0}, "ESTAT after TICLR");
        repeat (TIMER_WAIT) next_cycle();
        verify_reg(`CSR_ADDR_ESTAT, {10'd0, exp_ecode, 16'd0}, "ESTAT with one-shot idle");

        write_reg(`CSR_ADDR_TCFG, (TIMER_INIT << 2) | 3);
        wait_timer_irq(TIMER_WAIT);
        write_reg(`CSR_ADDR_TICLR, 32'h1);
        verify_reg(`CSR_ADDR_ESTAT, {10'd0, exp_ecode, 16'd0}, "ESTAT after periodic TICLR");
        wait_timer_irq(TIMER_WAIT);
        write_reg(`CSR_ADDR_TCFG, 32'd0);
        write_reg(`CSR_ADDR_TICLR, 32'h1);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/csr_interrupt.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_interrupt (
    input  wire                     clk,
    input  wire                     aresetn,
    input  wire csr_pkg::csr_addr_t addr,
    input  wire csr_pkg::csr_data_t wdata,
    input  wire                     csr_we,
    input  wire csr_pkg::hw_int_t   hw_int,
    input  wire                     timer_irq,
    input  wire                     crmd_ie,
    output csr_pkg::csr_data_t      ecfg,
    output csr_pkg::int_vec_t       int_status,
    output logic                    cpu_interrupt,
    output logic                    idle_over
);
    import csr_pkg::*;

    int_vec_t   ecfg_lie;
    logic [1:0] estat_soft;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_lie   <= '0;
            estat_soft <= '0;
        end else if (csr_we) begin
            if (addr == `CSR_ADDR_ECFG) begin
                ecfg_lie <= wdata[`CSR_INT_W-1:0];
            end
            // Only the two software bits of ESTAT are writable
            if (addr == `CSR_ADDR_ESTAT) begin
                estat_soft <= wdata[`CSR_ESTAT_IS_SOFT];
            end
        end
    end

    always_comb begin
        int_status = '0;
        int_status[`CSR_ESTAT_IS_SOFT] = estat_soft;
        int_status[`CSR_ESTAT_HW_LSB +: `CSR_HWINT_W] = hw_int;
        int_status[`CSR_ESTAT_TI_BIT] = timer_irq;
    end

    assign ecfg = {{(32 - `CSR_INT_W){1'b0}}, ecfg_lie};

    // Needs global enable and a matching local enable
    assign cpu_interrupt = crmd_ie && |(int_status & ecfg_lie);

    // Any pending source ends idle, enabled or not
    assign idle_over = |int_status;

endmodule

`default_nettype wire

//--- src/csr_mode_exc.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_mode_exc (
    input  wire                  clk,
    input  wire                  aresetn,
    input  wire csr_pkg::csr_addr_t addr,
    input  wire csr_pkg::csr_data_t wdata,
    input  wire                  csr_we,
    input  wire                  exception,
    input  wire                  ertn,
    input  wire csr_pkg::ecode_t ex_ecode,
    input  wire csr_pkg::csr_data_t ex_pc,
    input  wire                  badv_valid,
    input  wire csr_pkg::csr_data_t badv_in,
    output csr_pkg::csr_data_t   crmd,
    output csr_pkg::csr_data_t   prmd,
    output csr_pkg::csr_data_t   era,
    output csr_pkg::csr_data_t   badv,
    output csr_pkg::csr_data_t   eentry,
    output csr_pkg::ecode_t      ecode,
    output logic                 crmd_ie
);
    import csr_pkg::*;

    localparam csr_data_t CRMD_INIT = `CSR_CRMD_RESET;

    plv_t                         crmd_plv;
    logic                         crmd_da;
    logic                         crmd_pg;
    logic [1:0]                   crmd_datf;
    logic [1:0]                   crmd_datm;
    plv_t                         prmd_pplv;
    logic                         prmd_pie;
    logic [31:`CSR_EENTRY_LSB]    eentry_va;
    logic                         ex_take;

    // ertn wins over a simultaneous exception
    assign ex_take = exception && !ertn;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_plv  <= CRMD_INIT[`CSR_CRMD_PLV];
            crmd_ie   <= CRMD_INIT[`CSR_CRMD_IE];
            crmd_da   <= CRMD_INIT[`CSR_CRMD_DA];
            crmd_pg   <= CRMD_INIT[`CSR_CRMD_PG];
            crmd_datf <= CRMD_INIT[`CSR_CRMD_DATF];
            crmd_datm <= CRMD_INIT[`CSR_CRMD_DATM];
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (ex_take) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (csr_we && addr == `CSR_ADDR_CRMD) begin
            crmd_plv  <= wdata[`CSR_CRMD_PLV];
            crmd_ie   <= wdata[`CSR_CRMD_IE];
            crmd_datf <= wdata[`CSR_CRMD_DATF];
            crmd_datm <= wdata[`CSR_CRMD_DATM];
            // Only DA/PG = 01 or 10 is legal
            if (wdata[`CSR_CRMD_DA] != wdata[`CSR_CRMD_PG]) begin
                crmd_da <= wdata[`CSR_CRMD_DA];
                crmd_pg <= wdata[`CSR_CRMD_PG];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (ex_take) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && addr == `CSR_ADDR_PRMD) begin
            prmd_pplv <= wdata[`CSR_PRMD_PPLV];
            prmd_pie  <= wdata[`CSR_PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era   <= '0;
            badv  <= '0;
            ecode <= '0;
        end else if (ex_take) begin
            era   <= ex_pc;
            ecode <= ex_ecode;
            if (badv_valid) begin
                badv <= badv_in;
            end
        end else if (csr_we) begin
            if (addr == `CSR_ADDR_ERA) begin
                era <= wdata;
            end
            if (addr == `CSR_ADDR_BADV) begin
                badv <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            eentry_va <= '0;
        end else if (csr_we && addr == `CSR_ADDR_EENTRY) begin
            eentry_va <= wdata[31:`CSR_EENTRY_LSB];
        end
    end

    always_comb begin
        crmd                 = '0;
        crmd[`CSR_CRMD_PLV]  = crmd_plv;
        crmd[`CSR_CRMD_IE]   = crmd_ie;
        crmd[`CSR_CRMD_DA]   = crmd_da;
        crmd[`CSR_CRMD_PG]   = crmd_pg;
        crmd[`CSR_CRMD_DATF] = crmd_datf;
        crmd[`CSR_CRMD_DATM] = crmd_datm;

        prmd                 = '0;
        prmd[`CSR_PRMD_PPLV] = prmd_pplv;
        prmd[`CSR_PRMD_PIE]  = prmd_pie;
    end

    assign eentry = {eentry_va, {`CSR_EENTRY_LSB{1'b0}}};

endmodule

`default_nettype wire

//--- src/csr_pkg.sv
`default_nettype none

`include "csr_settings.svh"

package csr_pkg;

    // CSR address as seen by software
    typedef logic [13:0] csr_addr_t;

    typedef logic [31:0] csr_data_t;

    // Privilege level, 0 is the most privileged
    typedef logic [1:0] plv_t;

    typedef logic [5:0] ecode_t;

    // Interrupt status and enable, same layout as ESTAT[12:0]
    typedef logic [`CSR_INT_W-1:0] int_vec_t;

    typedef logic [`CSR_HWINT_W-1:0] hw_int_t;

    // TCFG InitVal, counter loads it shifted left by two
    typedef logic [`CSR_TIMER_INIT_W-1:0] timer_init_t;

endpackage

`default_nettype wire

//--- src/csr_read_mux.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_read_mux (
    input  wire csr_pkg::csr_addr_t addr,
    input  wire csr_pkg::csr_data_t crmd,
    input  wire csr_pkg::csr_data_t prmd,
    input  wire csr_pkg::csr_data_t ecfg,
    input  wire csr_pkg::csr_data_t era,
    input  wire csr_pkg::csr_data_t badv,
    input  wire csr_pkg::csr_data_t eentry,
    input  wire csr_pkg::csr_data_t save0,
    input  wire csr_pkg::csr_data_t save1,
    input  wire csr_pkg::csr_data_t save2,
    input  wire csr_pkg::csr_data_t save3,
    input  wire csr_pkg::csr_data_t tid,
    input  wire csr_pkg::csr_data_t tcfg,
    input  wire csr_pkg::csr_data_t tval,
    input  wire csr_pkg::ecode_t    ecode,
    input  wire csr_pkg::int_vec_t  int_status,
    output csr_pkg::csr_data_t      rdata
);
    import csr_pkg::*;

    csr_data_t estat;

    always_comb begin
        estat = '0;
        estat[`CSR_INT_W-1:0]   = int_status;
        estat[`CSR_ESTAT_ECODE] = ecode;
    end

    // TICLR reads as zero, like any unmapped address
    always_comb begin
        case (addr)
            `CSR_ADDR_CRMD:   rdata = crmd;
            `CSR_ADDR_PRMD:   rdata = prmd;
            `CSR_ADDR_ECFG:   rdata = ecfg;
            `CSR_ADDR_ESTAT:  rdata = estat;
            `CSR_ADDR_ERA:    rdata = era;
            `CSR_ADDR_BADV:   rdata = badv;
            `CSR_ADDR_EENTRY: rdata = eentry;
            `CSR_ADDR_SAVE0:  rdata = save0;
            `CSR_ADDR_SAVE1:  rdata = save1;
            `CSR_ADDR_SAVE2:  rdata = save2;
            `CSR_ADDR_SAVE3:  rdata = save3;
            `CSR_ADDR_TID:    rdata = tid;
            `CSR_ADDR_TCFG:   rdata = tcfg;
            `CSR_ADDR_TVAL:   rdata = tval;
            default:          rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/csr_scratch.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_scratch (
    input  wire                     clk,
    input  wire                     aresetn,
    input  wire csr_pkg::csr_addr_t addr,
    input  wire csr_pkg::csr_data_t wdata,
    input  wire                     csr_we,
    output csr_pkg::csr_data_t      save0,
    output csr_pkg::csr_data_t      save1,
    output csr_pkg::csr_data_t      save2,
    output csr_pkg::csr_data_t      save3,
    output csr_pkg::csr_data_t      tid
);
    import csr_pkg::*;

    csr_data_t save_q [4];
    logic      save_hit;

    // SAVE0..3 sit on four consecutive addresses
    assign save_hit = {addr[13:2], 2'b00} == `CSR_ADDR_SAVE0;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
            tid <= '0;
        end else if (csr_we) begin
            if (save_hit) begin
                save_q[addr[1:0]] <= wdata;
            end
            if (addr == `CSR_ADDR_TID) begin
                tid <= wdata;
            end
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

`default_nettype wire

//--- src/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// CSR addresses
`define CSR_ADDR_CRMD    14'h000
`define CSR_ADDR_PRMD    14'h001
`define CSR_ADDR_ECFG    14'h004
`define CSR_ADDR_ESTAT   14'h005
`define CSR_ADDR_ERA     14'h006
`define CSR_ADDR_BADV    14'h007
`define CSR_ADDR_EENTRY  14'h00C
`define CSR_ADDR_SAVE0   14'h030
`define CSR_ADDR_SAVE1   14'h031
`define CSR_ADDR_SAVE2   14'h032
`define CSR_ADDR_SAVE3   14'h033
`define CSR_ADDR_TID     14'h040
`define CSR_ADDR_TCFG    14'h041
`define CSR_ADDR_TVAL    14'h042
`define CSR_ADDR_TICLR   14'h044

// CRMD and PRMD fields
`define CSR_CRMD_RESET   32'h0000_00A8
`define CSR_CRMD_PLV     1:0
`define CSR_CRMD_IE      2
`define CSR_CRMD_DA      3
`define CSR_CRMD_PG      4
`define CSR_CRMD_DATF    6:5
`define CSR_CRMD_DATM    8:7
`define CSR_PRMD_PPLV    1:0
`define CSR_PRMD_PIE     2

// ESTAT, ECFG and timer fields
`define CSR_INT_W        13
`define CSR_HWINT_W      8
`define CSR_ESTAT_HW_LSB 2
`define CSR_ESTAT_IS_SOFT 1:0
`define CSR_ESTAT_TI_BIT 11
`define CSR_ESTAT_ECODE  21:16
`define CSR_TIMER_INIT_W 30
`define CSR_TCFG_EN      0
`define CSR_TCFG_PERIODIC 1
`define CSR_EENTRY_LSB   6

`endif

//--- src/csr_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_timer (
    input  wire                     clk,
    input  wire                     aresetn,
    input  wire csr_pkg::csr_addr_t addr,
    input  wire csr_pkg::csr_data_t wdata,
    input  wire                     csr_we,
    output csr_pkg::csr_data_t      tcfg,
    output csr_pkg::csr_data_t      tval,
    output logic                    timer_irq
);
    import csr_pkg::*;

    logic        tcfg_en;
    logic        tcfg_periodic;
    timer_init_t tcfg_init;
    logic        tcfg_wr;
    logic        ticlr_wr;
    logic        load_req;
    logic        time_out;
    logic        reload;

    assign tcfg_wr  = csr_we && addr == `CSR_ADDR_TCFG;
    assign ticlr_wr = csr_we && addr == `CSR_ADDR_TICLR;

    // Fresh TCFG write, or periodic wrap at zero
    assign reload = load_req || (tcfg_en && tcfg_periodic && tval == '0);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_init     <= '0;
            load_req      <= 1'b0;
        end else begin
            load_req <= tcfg_wr;
            if (tcfg_wr) begin
                tcfg_en       <= wdata[`CSR_TCFG_EN];
                tcfg_periodic <= wdata[`CSR_TCFG_PERIODIC];
                tcfg_init     <= wdata[31:2];
            end
        end
    end

    // Load value is one above InitVal<<2 so that InitVal 0 still fires
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval     <= '0;
            time_out <= 1'b0;
        end else begin
            time_out <= !load_req && tcfg_en && tval == 32'd1;
            if (reload) begin
                tval <= {tcfg_init, 2'b01};
            end else if (tcfg_en && tval != '0) begin
                tval <= tval - 32'd1;
            end
        end
    end

    // Clear beats a set in the same cycle
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            timer_irq <= 1'b0;
        end else if (ticlr_wr) begin
            timer_irq <= 1'b0;
        end else if (time_out) begin
            timer_irq <= 1'b1;
        end
    end

    assign tcfg = {tcfg_init, tcfg_periodic, tcfg_en};

endmodule

`default_nettype wire

//--- src/csr_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_top (
    input  wire                     clk,
    input  wire                     aresetn,
    input  wire csr_pkg::csr_addr_t addr,
    input  wire csr_pkg::csr_data_t wdata,
    input  wire                     csr_we,
    input  wire                     exception,
    input  wire                     ertn,
    input  wire csr_pkg::ecode_t    ex_ecode,
    input  wire csr_pkg::csr_data_t ex_pc,
    input  wire                     badv_valid,
    input  wire csr_pkg::csr_data_t badv_in,
    input  wire csr_pkg::hw_int_t   hw_int,
    output csr_pkg::csr_data_t      rdata,
    output csr_pkg::plv_t           plv,
    output csr_pkg::csr_data_t      era_out,
    output csr_pkg::csr_data_t      eentry_out,
    output csr_pkg::csr_data_t      tid_out,
    output logic                    cpu_interrupt,
    output logic                    idle_over
);
    import csr_pkg::*;

    wire csr_data_t crmd;
    wire csr_data_t prmd;
    wire csr_data_t badv;
    wire csr_data_t ecfg;
    wire csr_data_t tcfg;
    wire csr_data_t tval;
    wire csr_data_t save0;
    wire csr_data_t save1;
    wire csr_data_t save2;
    wire csr_data_t save3;
    wire ecode_t    ecode;
    wire int_vec_t  int_status;
    wire            crmd_ie;
    wire            timer_irq;

    assign plv = crmd[`CSR_CRMD_PLV];

    csr_mode_exc u_mode_exc (
        .clk        (clk),
        .aresetn    (aresetn),
        .addr       (addr),
        .wdata      (wdata),
        .csr_we     (csr_we),
        .exception  (exception),
        .ertn       (ertn),
        .ex_ecode   (ex_ecode),
        .ex_pc      (ex_pc),
        .badv_valid (badv_valid),
        .badv_in    (badv_in),
        .crmd       (crmd),
        .prmd       (prmd),
        .era        (era_out),
        .badv       (badv),
        .eentry     (eentry_out),
        .ecode      (ecode),
        .crmd_ie    (crmd_ie)
    );

    csr_interrupt u_interrupt (
        .clk           (clk),
        .aresetn       (aresetn),
        .addr          (addr),
        .wdata         (wdata),
        .csr_we        (csr_we),
        .hw_int        (hw_int),
        .timer_irq     (timer_irq),
        .crmd_ie       (crmd_ie),
        .ecfg          (ecfg),
        .int_status    (int_status),
        .cpu_interrupt (cpu_interrupt),
        .idle_over     (idle_over)
    );

    csr_timer u_timer (
        .clk       (clk),
        .aresetn   (aresetn),
        .addr      (addr),
        .wdata     (wdata),
        .csr_we    (csr_we),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_irq (timer_irq)
    );

    csr_scratch u_scratch (
        .clk     (clk),
        .aresetn (aresetn),
        .addr    (addr),
        .wdata   (wdata),
        .csr_we  (csr_we),
        .save0   (save0),
        .save1   (save1),
        .save2   (save2),
        .save3   (save3),
        .tid     (tid_out)
    );

    csr_read_mux u_read_mux (
        .addr       (addr),
        .crmd       (crmd),
        .prmd       (prmd),
        .ecfg       (ecfg),
        .era        (era_out),
        .badv       (badv),
        .eentry     (eentry_out),
        .save0      (save0),
        .save1      (save1),
        .save2      (save2),
        .save3      (save3),
        .tid        (tid_out),
        .tcfg       (tcfg),
        .tval       (tval),
        .ecode      (ecode),
        .int_status (int_status),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire
